// File: include/pcie_config_settings.svh
`ifndef PCIE_CONFIG_SETTINGS_SVH
`define PCIE_CONFIG_SETTINGS_SVH

// Bus and descriptor widths
`define AXIL_DATA_W 32
`define AXIL_ADDR_W 32
`define PCIE_ADDR_W 64
`define RAM_ADDR_W  32
`define DMA_LEN_W   16
`define DMA_TAG_W   32

// Identification registers
`define REG_FW_ID     16'h0000
`define REG_FW_VER    16'h0004
`define REG_BOARD_ID  16'h0008
`define REG_BOARD_VER 16'h000C
`define REG_IF_COUNT  16'h0020

`define REG_GPIO_OUT 16'h0100
`define REG_GPIO_IN  16'h0104

`define REG_DMA_ENABLE 16'h0400

// Descriptor channel bases and offsets within a channel
`define REG_DMA_RD_BASE 16'h0440
`define REG_DMA_WR_BASE 16'h0460
`define DMA_OFS_ADDR_LO 16'h0000
`define DMA_OFS_ADDR_HI 16'h0004
`define DMA_OFS_RAM     16'h0008
`define DMA_OFS_LEN     16'h0010
`define DMA_OFS_TAG     16'h0014
`define DMA_OFS_STATUS  16'h0018

`define FW_ID_VAL     32'h0000_0000
`define FW_VER_VAL    32'h0000_0001
`define BOARD_ID_VAL  32'h1CE4_0003
`define BOARD_VER_VAL 32'h0000_0001
`define IF_COUNT_VAL  32'd2

// GPIO bit positions, shared by the out and in registers
`define GPIO_Q1_RESETL  0
`define GPIO_Q1_INTL    1
`define GPIO_Q1_LPMODE  2
`define GPIO_Q2_RESETL  4
`define GPIO_Q2_INTL    5
`define GPIO_Q2_LPMODE  6
`define GPIO_Q1_MODPRSL 8
`define GPIO_Q1_MODSELL 9
`define GPIO_Q2_MODPRSL 10
`define GPIO_Q2_MODSELL 11
`define GPIO_SCL        16
`define GPIO_SDA        17

`endif

// File: logic/pcie_config_pkg.sv
`default_nettype none

`include "pcie_config_settings.svh"

package pcie_config_pkg;

  typedef logic [`AXIL_DATA_W-1:0]   axil_data_t;
  typedef logic [`AXIL_DATA_W/8-1:0] axil_strb_t;
  typedef logic [15:0]               reg_ofs_t;
  typedef logic [`PCIE_ADDR_W-1:0]   pcie_addr_t;
  typedef logic [`RAM_ADDR_W-1:0]    ram_addr_t;
  typedef logic [`DMA_LEN_W-1:0]     dma_len_t;
  typedef logic [`DMA_TAG_W-1:0]     dma_tag_t;

  // Accepted write, strobe high for one cycle
  typedef struct packed {
    logic       strobe;
    reg_ofs_t   ofs;
    axil_data_t data;
    axil_strb_t strb;
  } reg_wr_t;

  typedef struct packed {
    logic     strobe;
    reg_ofs_t ofs;
  } reg_rd_t;

  typedef struct packed {
    pcie_addr_t pcie_addr;
    ram_addr_t  ram_addr;
    dma_len_t   len;
    dma_tag_t   tag;
  } dma_desc_t;

  // One QSFP cage, all active-low except lpmode
  typedef struct packed {
    logic modsell;
    logic resetl;
    logic lpmode;
  } qsfp_ctrl_t;

  typedef struct packed {
    logic modprsl;
    logic intl;
  } qsfp_stat_t;

endpackage

`default_nettype wire

// File: logic/cfg_bus_slave.sv
`default_nettype none

`include "pcie_config_settings.svh"

module cfg_bus_slave
  import pcie_config_pkg::*;
(
  input  wire                     pcie_clk,
  input  wire                     pcie_rst,

  input  wire [`AXIL_ADDR_W-1:0]  s_awaddr_i,
  input  wire                     s_awvalid_i,
  output logic                    s_awready_o,
  input  axil_data_t              s_wdata_i,
  input  axil_strb_t              s_wstrb_i,
  input  wire                     s_wvalid_i,
  output logic                    s_wready_o,
  output logic [1:0]              s_bresp_o,
  output logic                    s_bvalid_o,
  input  wire                     s_bready_i,
  input  wire [`AXIL_ADDR_W-1:0]  s_araddr_i,
  input  wire                     s_arvalid_i,
  output logic                    s_arready_o,
  output axil_data_t              s_rdata_o,
  output logic [1:0]              s_rresp_o,
  output logic                    s_rvalid_o,
  input  wire                     s_rready_i,

  output reg_wr_t                 reg_wr_o,
  output reg_rd_t                 reg_rd_o,

  input  axil_data_t              ctrl_rdata_i,
  input  axil_data_t              gpio_rdata_i,
  input  axil_data_t              dma_rd_rdata_i,
  input  axil_data_t              dma_wr_rdata_i
);

  logic       wr_accept;
  logic       rd_accept;
  axil_data_t rdata_or;

  // Address and data must arrive together, one write in flight
  assign wr_accept = s_awvalid_i && s_wvalid_i && !s_bvalid_o;
  // rvalid still high holds off the next read
  assign rd_accept = s_arvalid_i && !s_rvalid_o;

  assign reg_wr_o = '{
    strobe: wr_accept,
    ofs:    {s_awaddr_i[15:2], 2'b00},
    data:   s_wdata_i,
    strb:   s_wstrb_i
  };

  assign reg_rd_o = '{
    strobe: rd_accept,
    ofs:    {s_araddr_i[15:2], 2'b00}
  };

  // Blocks return zero outside their own offsets
  assign rdata_or = ctrl_rdata_i | gpio_rdata_i | dma_rd_rdata_i | dma_wr_rdata_i;

  assign s_bresp_o = 2'b00;
  assign s_rresp_o = 2'b00;

  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      s_awready_o <= 1'b0;
      s_wready_o  <= 1'b0;
      s_bvalid_o  <= 1'b0;
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
    end else begin
      s_awready_o <= wr_accept;
      s_wready_o  <= wr_accept;
      s_bvalid_o  <= wr_accept || (s_bvalid_o && !s_bready_i);
      s_arready_o <= rd_accept;
      s_rvalid_o  <= rd_accept || (s_rvalid_o && !s_rready_i);
    end
  end

  always_ff @(posedge pcie_clk) begin
    if (rd_accept) begin
      s_rdata_o <= rdata_or;
    end
  end

endmodule

`default_nettype wire

// File: logic/ctrl_regs.sv
`default_nettype none

`include "pcie_config_settings.svh"

module ctrl_regs
  import pcie_config_pkg::*;
(
  input  wire        pcie_clk,
  input  wire        pcie_rst,
  input  reg_wr_t    reg_wr_i,
  input  reg_rd_t    reg_rd_i,
  output axil_data_t rdata_o,
  output logic       dma_enable_o
);

  // DMA runs by default out of reset
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      dma_enable_o <= 1'b1;
    end else if (reg_wr_i.strobe && reg_wr_i.ofs == `REG_DMA_ENABLE) begin
      dma_enable_o <= reg_wr_i.data[0];
    end
  end

  always_comb begin
    rdata_o = '0;
    case (reg_rd_i.ofs)
      `REG_FW_ID:      rdata_o = `FW_ID_VAL;
      `REG_FW_VER:     rdata_o = `FW_VER_VAL;
      `REG_BOARD_ID:   rdata_o = `BOARD_ID_VAL;
      `REG_BOARD_VER:  rdata_o = `BOARD_VER_VAL;
      `REG_IF_COUNT:   rdata_o = `IF_COUNT_VAL;
      `REG_DMA_ENABLE: rdata_o[0] = dma_enable_o;
      default:         rdata_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/gpio_regs.sv
`default_nettype none

`include "pcie_config_settings.svh"

module gpio_regs
  import pcie_config_pkg::*;
(
  input  wire        pcie_clk,
  input  wire        pcie_rst,
  input  reg_wr_t    reg_wr_i,
  input  reg_rd_t    reg_rd_i,
  output axil_data_t rdata_o,

  output qsfp_ctrl_t qsfp1_ctrl_o,
  output qsfp_ctrl_t qsfp2_ctrl_o,
  input  qsfp_stat_t qsfp1_stat_i,
  input  qsfp_stat_t qsfp2_stat_i,

  input  wire        i2c_scl_i,
  input  wire        i2c_sda_i,
  output logic       i2c_scl_o,
  output logic       i2c_sda_o,
  output logic       i2c_scl_t_o,
  output logic       i2c_sda_t_o
);

  localparam qsfp_ctrl_t CTRL_IDLE = '{modsell: 1'b1, resetl: 1'b1, lpmode: 1'b0};

  qsfp_ctrl_t q1_ctrl_q;
  qsfp_ctrl_t q2_ctrl_q;
  logic       scl_q;
  logic       sda_q;
  qsfp_stat_t q1_stat_sync;
  qsfp_stat_t q2_stat_sync;
  logic       scl_in_sync;
  logic       sda_in_sync;
  logic       out_hit;

  assign out_hit = reg_wr_i.strobe && reg_wr_i.ofs == `REG_GPIO_OUT;

  // Software view of the outputs, one field group per byte lane
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      q1_ctrl_q <= CTRL_IDLE;
      q2_ctrl_q <= CTRL_IDLE;
      scl_q     <= 1'b1;
      sda_q     <= 1'b1;
    end else if (out_hit) begin
      if (reg_wr_i.strb[0]) begin
        q1_ctrl_q.resetl <= reg_wr_i.data[`GPIO_Q1_RESETL];
        q1_ctrl_q.lpmode <= reg_wr_i.data[`GPIO_Q1_LPMODE];
        q2_ctrl_q.resetl <= reg_wr_i.data[`GPIO_Q2_RESETL];
        q2_ctrl_q.lpmode <= reg_wr_i.data[`GPIO_Q2_LPMODE];
      end
      if (reg_wr_i.strb[1]) begin
        q1_ctrl_q.modsell <= reg_wr_i.data[`GPIO_Q1_MODSELL];
        q2_ctrl_q.modsell <= reg_wr_i.data[`GPIO_Q2_MODSELL];
      end
      if (reg_wr_i.strb[2]) begin
        scl_q <= reg_wr_i.data[`GPIO_SCL];
        sda_q <= reg_wr_i.data[`GPIO_SDA];
      end
    end
  end

  // Pin retiming and input sync share one stage
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      qsfp1_ctrl_o <= CTRL_IDLE;
      qsfp2_ctrl_o <= CTRL_IDLE;
      i2c_scl_o    <= 1'b1;
      i2c_sda_o    <= 1'b1;
      q1_stat_sync <= '0;
      q2_stat_sync <= '0;
      scl_in_sync  <= 1'b1;
      sda_in_sync  <= 1'b1;
    end else begin
      qsfp1_ctrl_o <= q1_ctrl_q;
      qsfp2_ctrl_o <= q2_ctrl_q;
      i2c_scl_o    <= scl_q;
      i2c_sda_o    <= sda_q;
      q1_stat_sync <= qsfp1_stat_i;
      q2_stat_sync <= qsfp2_stat_i;
      scl_in_sync  <= i2c_scl_i;
      sda_in_sync  <= i2c_sda_i;
    end
  end

  // Open drain, release the line when driving high
  assign i2c_scl_t_o = i2c_scl_o;
  assign i2c_sda_t_o = i2c_sda_o;

  always_comb begin
    rdata_o = '0;
    if (reg_rd_i.ofs == `REG_GPIO_OUT || reg_rd_i.ofs == `REG_GPIO_IN) begin
      rdata_o[`GPIO_Q1_RESETL]  = q1_ctrl_q.resetl;
      rdata_o[`GPIO_Q1_LPMODE]  = q1_ctrl_q.lpmode;
      rdata_o[`GPIO_Q2_RESETL]  = q2_ctrl_q.resetl;
      rdata_o[`GPIO_Q2_LPMODE]  = q2_ctrl_q.lpmode;
      rdata_o[`GPIO_Q1_MODSELL] = q1_ctrl_q.modsell;
      rdata_o[`GPIO_Q2_MODSELL] = q2_ctrl_q.modsell;
      rdata_o[`GPIO_SCL]        = scl_q;
      rdata_o[`GPIO_SDA]        = sda_q;
    end
    // I2C bits show the bus level here, not the driven one
    if (reg_rd_i.ofs == `REG_GPIO_IN) begin
      rdata_o[`GPIO_Q1_INTL]    = q1_stat_sync.intl;
      rdata_o[`GPIO_Q2_INTL]    = q2_stat_sync.intl;
      rdata_o[`GPIO_Q1_MODPRSL] = q1_stat_sync.modprsl;
      rdata_o[`GPIO_Q2_MODPRSL] = q2_stat_sync.modprsl;
      rdata_o[`GPIO_SCL]        = scl_in_sync;
      rdata_o[`GPIO_SDA]        = sda_in_sync;
    end
  end

endmodule

`default_nettype wire

// File: logic/dma_desc_channel.sv
`default_nettype none

`include "pcie_config_settings.svh"

module dma_desc_channel
  import pcie_config_pkg::*;
#(
  parameter reg_ofs_t BASE_OFS = `REG_DMA_RD_BASE
) (
  input  wire        pcie_clk,
  input  wire        pcie_rst,
  input  reg_wr_t    reg_wr_i,
  input  reg_rd_t    reg_rd_i,
  output axil_data_t rdata_o,

  output dma_desc_t  desc_o,
  output logic       desc_valid_o,
  input  wire        desc_ready_i,

  input  dma_tag_t   status_tag_i,
  input  wire        status_valid_i
);

  localparam reg_ofs_t OFS_ADDR_LO = BASE_OFS + `DMA_OFS_ADDR_LO;
  localparam reg_ofs_t OFS_ADDR_HI = BASE_OFS + `DMA_OFS_ADDR_HI;
  localparam reg_ofs_t OFS_RAM     = BASE_OFS + `DMA_OFS_RAM;
  localparam reg_ofs_t OFS_LEN     = BASE_OFS + `DMA_OFS_LEN;
  localparam reg_ofs_t OFS_TAG     = BASE_OFS + `DMA_OFS_TAG;
  localparam reg_ofs_t OFS_STATUS  = BASE_OFS + `DMA_OFS_STATUS;

  logic     wr_open;
  logic     status_clr;
  dma_tag_t status_tags;

  // Fields are frozen while the engine has not taken the descriptor
  assign wr_open    = reg_wr_i.strobe && !desc_valid_o;
  assign status_clr = reg_rd_i.strobe && reg_rd_i.ofs == OFS_STATUS;

  always_ff @(posedge pcie_clk) begin
    if (wr_open) begin
      case (reg_wr_i.ofs)
        OFS_ADDR_LO: desc_o.pcie_addr[31:0]  <= reg_wr_i.data;
        OFS_ADDR_HI: desc_o.pcie_addr[63:32] <= reg_wr_i.data;
        OFS_RAM:     desc_o.ram_addr         <= reg_wr_i.data;
        OFS_LEN:     desc_o.len              <= reg_wr_i.data[`DMA_LEN_W-1:0];
        OFS_TAG:     desc_o.tag              <= reg_wr_i.data;
        default:     desc_o                  <= desc_o;
      endcase
    end
  end

  // Tag write launches the descriptor
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      desc_valid_o <= 1'b0;
    end else if (wr_open && reg_wr_i.ofs == OFS_TAG) begin
      desc_valid_o <= 1'b1;
    end else if (desc_ready_i) begin
      desc_valid_o <= 1'b0;
    end
  end

  // Clear on read, a tag landing in the same cycle survives the clear
  always_ff @(posedge pcie_clk) begin
    if (pcie_rst) begin
      status_tags <= '0;
    end else if (status_clr) begin
      status_tags <= status_valid_i ? status_tag_i : '0;
    end else if (status_valid_i) begin
      status_tags <= status_tags | status_tag_i;
    end
  end

  assign rdata_o = (reg_rd_i.ofs == OFS_STATUS) ? status_tags : '0;

endmodule

`default_nettype wire

// File: logic/pcie_config.sv
`default_nettype none

`include "pcie_config_settings.svh"

module pcie_config
  import pcie_config_pkg::*;
(
  input  wire                     pcie_clk,
  input  wire                     pcie_rst,

  input  wire [`AXIL_ADDR_W-1:0]  s_awaddr_i,
  input  wire                     s_awvalid_i,
  output logic                    s_awready_o,
  input  axil_data_t              s_wdata_i,
  input  axil_strb_t              s_wstrb_i,
  input  wire                     s_wvalid_i,
  output logic                    s_wready_o,
  output logic [1:0]              s_bresp_o,
  output logic                    s_bvalid_o,
  input  wire                     s_bready_i,
  input  wire [`AXIL_ADDR_W-1:0]  s_araddr_i,
  input  wire                     s_arvalid_i,
  output logic                    s_arready_o,
  output axil_data_t              s_rdata_o,
  output logic [1:0]              s_rresp_o,
  output logic                    s_rvalid_o,
  input  wire                     s_rready_i,

  output qsfp_ctrl_t              qsfp1_ctrl_o,
  output qsfp_ctrl_t              qsfp2_ctrl_o,
  input  qsfp_stat_t              qsfp1_stat_i,
  input  qsfp_stat_t              qsfp2_stat_i,
  input  wire                     i2c_scl_i,
  input  wire                     i2c_sda_i,
  output logic                    i2c_scl_o,
  output logic                    i2c_sda_o,
  output logic                    i2c_scl_t_o,
  output logic                    i2c_sda_t_o,

  output logic                    dma_enable_o,

  output dma_desc_t               rd_desc_o,
  output logic                    rd_desc_valid_o,
  input  wire                     rd_desc_ready_i,
  input  dma_tag_t                rd_desc_status_tag_i,
  input  wire                     rd_desc_status_valid_i,

  output dma_desc_t               wr_desc_o,
  output logic                    wr_desc_valid_o,
  input  wire                     wr_desc_ready_i,
  input  dma_tag_t                wr_desc_status_tag_i,
  input  wire                     wr_desc_status_valid_i
);

  reg_wr_t    reg_wr;
  reg_rd_t    reg_rd;
  axil_data_t ctrl_rdata;
  axil_data_t gpio_rdata;
  axil_data_t dma_rd_rdata;
  axil_data_t dma_wr_rdata;

  cfg_bus_slave u_bus (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .s_awaddr_i     (s_awaddr_i),
    .s_awvalid_i    (s_awvalid_i),
    .s_awready_o    (s_awready_o),
    .s_wdata_i      (s_wdata_i),
    .s_wstrb_i      (s_wstrb_i),
    .s_wvalid_i     (s_wvalid_i),
    .s_wready_o     (s_wready_o),
    .s_bresp_o      (s_bresp_o),
    .s_bvalid_o     (s_bvalid_o),
    .s_bready_i     (s_bready_i),
    .s_araddr_i     (s_araddr_i),
    .s_arvalid_i    (s_arvalid_i),
    .s_arready_o    (s_arready_o),
    .s_rdata_o      (s_rdata_o),
    .s_rresp_o      (s_rresp_o),
    .s_rvalid_o     (s_rvalid_o),
    .s_rready_i     (s_rready_i),
    .reg_wr_o       (reg_wr),
    .reg_rd_o       (reg_rd),
    .ctrl_rdata_i   (ctrl_rdata),
    .gpio_rdata_i   (gpio_rdata),
    .dma_rd_rdata_i (dma_rd_rdata),
    .dma_wr_rdata_i (dma_wr_rdata)
  );

  ctrl_regs u_ctrl (
    .pcie_clk     (pcie_clk),
    .pcie_rst     (pcie_rst),
    .reg_wr_i     (reg_wr),
    .reg_rd_i     (reg_rd),
    .rdata_o      (ctrl_rdata),
    .dma_enable_o (dma_enable_o)
  );

  gpio_regs u_gpio (
    .pcie_clk     (pcie_clk),
    .pcie_rst     (pcie_rst),
    .reg_wr_i     (reg_wr),
    .reg_rd_i     (reg_rd),
    .rdata_o      (gpio_rdata),
    .qsfp1_ctrl_o (qsfp1_ctrl_o),
    .qsfp2_ctrl_o (qsfp2_ctrl_o),
    .qsfp1_stat_i (qsfp1_stat_i),
    .qsfp2_stat_i (qsfp2_stat_i),
    .i2c_scl_i    (i2c_scl_i),
    .i2c_sda_i    (i2c_sda_i),
    .i2c_scl_o    (i2c_scl_o),
    .i2c_sda_o    (i2c_sda_o),
    .i2c_scl_t_o  (i2c_scl_t_o),
    .i2c_sda_t_o  (i2c_sda_t_o)
  );

  // Host to card reads
  dma_desc_channel #(
    .BASE_OFS (`REG_DMA_RD_BASE)
  ) u_dma_rd (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .reg_wr_i       (reg_wr),
    .reg_rd_i       (reg_rd),
    .rdata_o        (dma_rd_rdata),
    .desc_o         (rd_desc_o),
    .desc_valid_o   (rd_desc_valid_o),
    .desc_ready_i   (rd_desc_ready_i),
    .status_tag_i   (rd_desc_status_tag_i),
    .status_valid_i (rd_desc_status_valid_i)
  );

  // Card to host writes
  dma_desc_channel #(
    .BASE_OFS (`REG_DMA_WR_BASE)
  ) u_dma_wr (
    .pcie_clk       (pcie_clk),
    .pcie_rst       (pcie_rst),
    .reg_wr_i       (reg_wr),
    .reg_rd_i       (reg_rd),
    .rdata_o        (dma_wr_rdata),
    .desc_o         (wr_desc_o),
    .desc_valid_o   (wr_desc_valid_o),
    .desc_ready_i   (wr_desc_ready_i),
    .status_tag_i   (wr_desc_status_tag_i),
    .status_valid_i (wr_desc_status_valid_i)
  );

endmodule

`default_nettype wire

// File: dv/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
  output logic pcie_clk_o,
  output logic pcie_rst_o
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    pcie_clk_o = 1'b0;
    forever #2 pcie_clk_o = ~pcie_clk_o;
  end

  initial begin
    pcie_rst_o = 1'b1;
    repeat (5) @(posedge pcie_clk_o);
    pcie_rst_o <= 1'b0;
  end

endmodule

`default_nettype wire

// File: dv/pcie_config_checker.sv
`default_nettype none

module pcie_config_checker
  import pcie_config_pkg::*;
(
  input wire       pcie_clk,
  input wire       pcie_rst,
  input wire       s_awready_i,
  input wire       s_bvalid_i,
  input wire       s_bready_i,
  input wire       s_rvalid_i,
  input wire       s_rready_i,
  input dma_desc_t rd_desc_i,
  input wire       rd_desc_valid_i,
  input wire       rd_desc_ready_i,
  input dma_desc_t wr_desc_i,
  input wire       wr_desc_valid_i,
  input wire       wr_desc_ready_i
);
  timeunit 1ns;
  timeprecision 1ps;

  a_bvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    s_bvalid_i && !s_bready_i |=> s_bvalid_i)
    else $error("bvalid dropped before bready");

  a_rvalid_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    s_rvalid_i && !s_rready_i |=> s_rvalid_i)
    else $error("rvalid dropped before rready");

  // Engine must see a frozen descriptor until it takes it
  a_rd_desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    rd_desc_valid_i && !rd_desc_ready_i |=> rd_desc_valid_i && $stable(rd_desc_i))
    else $error("read descriptor changed or dropped before ready");

  a_wr_desc_hold: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    wr_desc_valid_i && !wr_desc_ready_i |=> wr_desc_valid_i && $stable(wr_desc_i))
    else $error("write descriptor changed or dropped before ready");

  a_aw_no_overlap: assert property (@(posedge pcie_clk) disable iff (pcie_rst)
    $rose(s_awready_i) |-> !$past(s_bvalid_i))
    else $error("awready rose while a write response was pending");

endmodule

bind pcie_config pcie_config_checker u_chk (
  .pcie_clk        (pcie_clk),
  .pcie_rst        (pcie_rst),
  .s_awready_i     (s_awready_o),
  .s_bvalid_i      (s_bvalid_o),
  .s_bready_i      (s_bready_i),
  .s_rvalid_i      (s_rvalid_o),
  .s_rready_i      (s_rready_i),
  .rd_desc_i       (rd_desc_o),
  .rd_desc_valid_i (rd_desc_valid_o),
  .rd_desc_ready_i (rd_desc_ready_i),
  .wr_desc_i       (wr_desc_o),
  .wr_desc_valid_i (wr_desc_valid_o),
  .wr_desc_ready_i (wr_desc_ready_i)
);

`default_nettype wire

// File: dv/pcie_config_tb.sv
`default_nettype none

`include "pcie_config_settings.svh"

module pcie_config_tb
  import pcie_config_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int OP_WR = 0;
  localparam int OP_RD = 1;
  localparam int OP_STAT = 2;
  localparam int OP_IDLE = 3;
  localparam int OP_PINS = 4;
  localparam int OP_DESC = 5;
  localparam logic [31:0] GPIN_IDLE = 32'h0003_0000;

  typedef struct {
    string       name;
    int          op;
    logic [15:0] ofs;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [31:0] gpin;
    logic [1:0]  rdy;
    logic [31:0] exp;
  } step_t;

  step_t      steps[$];
  bit         table_ready = 1'b0;
  integer     seed = 32'h8adf95c6;
  dma_desc_t  exp_desc [2];

  logic pcie_clk, pcie_rst;
  logic [31:0] awaddr, araddr;
  logic awvalid, wvalid, bready, arvalid, rready;
  axil_data_t wdata, rdata;
  axil_strb_t wstrb;
  logic awready, wready, bvalid, arready, rvalid;
  logic [1:0] bresp, rresp;
  qsfp_ctrl_t q1_ctrl, q2_ctrl;
  qsfp_stat_t q1_stat, q2_stat;
  logic scl_in, sda_in, scl_out, sda_out, scl_t, sda_t, dma_en;
  dma_desc_t rd_desc, wr_desc;
  logic rd_valid, wr_valid, rd_ready, wr_ready, rd_st_valid, wr_st_valid;
  dma_tag_t rd_st_tag, wr_st_tag;

  tb_clock_gen u_clk (.pcie_clk_o(pcie_clk), .pcie_rst_o(pcie_rst));

  pcie_config uut (
    .pcie_clk(pcie_clk), .pcie_rst(pcie_rst),
    .s_awaddr_i(awaddr), .s_awvalid_i(awvalid), .s_awready_o(awready),
    .s_wdata_i(wdata), .s_wstrb_i(wstrb), .s_wvalid_i(wvalid), .s_wready_o(wready),
    .s_bresp_o(bresp), .s_bvalid_o(bvalid), .s_bready_i(bready),
    .s_araddr_i(araddr), .s_arvalid_i(arvalid), .s_arready_o(arready),
    .s_rdata_o(rdata), .s_rresp_o(rresp), .s_rvalid_o(rvalid), .s_rready_i(rready),
    .qsfp1_ctrl_o(q1_ctrl), .qsfp2_ctrl_o(q2_ctrl),
    .qsfp1_stat_i(q1_stat), .qsfp2_stat_i(q2_stat),
    .i2c_scl_i(scl_in), .i2c_sda_i(sda_in), .i2c_scl_o(scl_out), .i2c_sda_o(sda_out),
    .i2c_scl_t_o(scl_t), .i2c_sda_t_o(sda_t), .dma_enable_o(dma_en),
    .rd_desc_o(rd_desc), .rd_desc_valid_o(rd_valid), .rd_desc_ready_i(rd_ready),
    .rd_desc_status_tag_i(rd_st_tag), .rd_desc_status_valid_i(rd_st_valid),
    .wr_desc_o(wr_desc), .wr_desc_valid_o(wr_valid), .wr_desc_ready_i(wr_ready),
    .wr_desc_status_tag_i(wr_st_tag), .wr_desc_status_valid_i(wr_st_valid)
  );

  task automatic add_step(input string name, input int op, input logic [15:0] ofs,
                          input logic [31:0] data, input logic [3:0] strb,
                          input logic [31:0] gpin, input logic [1:0] rdy,
                          input logic [31:0] exp);
    step_t s;
    s.name = name;
    s.op = op;
    s.ofs = ofs;
    s.data = data;
    s.strb = strb;
    s.gpin = gpin;
    s.rdy = rdy;
    s.exp = exp;
    steps.push_back(s);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    if (exp !== act) begin
      $display("Mismatch in %s: expected %08h, actual %08h", name, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "Check failed");
    end
  endtask

  function automatic logic [31:0] pin_word();
    logic [31:0] w;
    w = '0;
    w[`GPIO_Q1_RESETL] = q1_ctrl.resetl;
    w[`GPIO_Q1_LPMODE] = q1_ctrl.lpmode;
    w[`GPIO_Q2_RESETL] = q2_ctrl.resetl;
    w[`GPIO_Q2_LPMODE] = q2_ctrl.lpmode;
    w[`GPIO_Q1_MODSELL] = q1_ctrl.modsell;
    w[`GPIO_Q2_MODSELL] = q2_ctrl.modsell;
    w[`GPIO_SCL] = scl_out;
    w[`GPIO_SDA] = sda_out;
    // DMA enable rides in an unused bit
    w[31] = dma_en;
    return w;
  endfunction

  // Expected descriptor fields follow the register writes
  task automatic track_desc(input logic [15:0] ofs, input logic [31:0] data);
    int ch;
    logic [15:0] rel;
    ch = (ofs >= `REG_DMA_WR_BASE) ? 1 : 0;
    rel = ofs - (ch == 1 ? `REG_DMA_WR_BASE : `REG_DMA_RD_BASE);
    if (ofs < `REG_DMA_RD_BASE || ofs >= `REG_DMA_WR_BASE + 16'h0020) begin
      return;
    end
    case (rel)
      `DMA_OFS_ADDR_LO: exp_desc[ch].pcie_addr[31:0] = data;
      `DMA_OFS_ADDR_HI: exp_desc[ch].pcie_addr[63:32] = data;
      `DMA_OFS_RAM:     exp_desc[ch].ram_addr = data;
      `DMA_OFS_LEN:     exp_desc[ch].len = data[15:0];
      `DMA_OFS_TAG:     exp_desc[ch].tag = data;
      default: ;
    endcase
  endtask

  task automatic apply_step(input step_t s);
    dma_desc_t d;
    logic v;
    int ch;
    ch = (s.ofs >= `REG_DMA_WR_BASE) ? 1 : 0;
    @(posedge pcie_clk);
    q1_stat <= '{modprsl: s.gpin[`GPIO_Q1_MODPRSL], intl: s.gpin[`GPIO_Q1_INTL]};
    q2_stat <= '{modprsl: s.gpin[`GPIO_Q2_MODPRSL], intl: s.gpin[`GPIO_Q2_INTL]};
    scl_in <= s.gpin[`GPIO_SCL];
    sda_in <= s.gpin[`GPIO_SDA];
    rd_ready <= s.rdy[0];
    wr_ready <= s.rdy[1];
    case (s.op)
      OP_WR: begin
        awaddr <= {16'h0, s.ofs};
        wdata <= s.data;
        wstrb <= s.strb;
        awvalid <= 1'b1;
        wvalid <= 1'b1;
        bready <= 1'b0;
        track_desc(s.ofs, s.data);
        do @(negedge pcie_clk); while (!bvalid);
        check_value({s.name, " bresp"}, 32'h0, {30'h0, bresp});
        check_value({s.name, " aw/w ready"}, 32'h3, {30'h0, awready, wready});
        @(posedge pcie_clk);
        awvalid <= 1'b0;
        wvalid <= 1'b0;
        bready <= 1'b1;
        // Response held through a stalled bready, no second accept
        @(negedge pcie_clk);
        check_value({s.name, " bvalid hold"}, 32'h1, {29'h0, awready, wready, bvalid});
      end
      OP_RD: begin
        araddr <= {16'h0, s.ofs};
        arvalid <= 1'b1;
        rready <= 1'b0;
        do @(negedge pcie_clk); while (!rvalid);
        check_value(s.name, s.exp, rdata);
        check_value({s.name, " rresp"}, 32'h0, {30'h0, rresp});
        check_value({s.name, " arready"}, 32'h1, {31'h0, arready});
        @(posedge pcie_clk);
        arvalid <= 1'b0;
        rready <= 1'b1;
        // Arvalid still high on that edge and must be held off
        @(negedge pcie_clk);
        check_value({s.name, " rvalid hold"}, 32'h1, {30'h0, arready, rvalid});
        check_value({s.name, " rdata hold"}, s.exp, rdata);
      end
      OP_STAT: begin
        rd_st_valid <= (ch == 0);
        wr_st_valid <= (ch == 1);
        rd_st_tag <= s.data;
        wr_st_tag <= s.data;
        @(posedge pcie_clk);
        rd_st_valid <= 1'b0;
        wr_st_valid <= 1'b0;
        rd_st_tag <= $random(seed);
        wr_st_tag <= $random(seed);
      end
      OP_IDLE: repeat (2) @(posedge pcie_clk);
      OP_PINS: begin
        @(negedge pcie_clk);
        check_value(s.name, s.exp, pin_word());
        check_value({s.name, " i2c_t"}, {30'h0, s.exp[`GPIO_SDA], s.exp[`GPIO_SCL]},
                    {30'h0, sda_t, scl_t});
      end
      default: begin
        @(negedge pcie_clk);
        d = (ch == 1) ? wr_desc : rd_desc;
        v = (ch == 1) ? wr_valid : rd_valid;
        check_value({s.name, " valid"}, s.exp, {31'h0, v});
        if (s.exp[0]) begin
          check_value({s.name, " addr lo"}, exp_desc[ch].pcie_addr[31:0], d.pcie_addr[31:0]);
          check_value({s.name, " addr hi"}, exp_desc[ch].pcie_addr[63:32], d.pcie_addr[63:32]);
          check_value({s.name, " ram"}, exp_desc[ch].ram_addr, d.ram_addr);
          check_value({s.name, " len"}, {16'h0, exp_desc[ch].len}, {16'h0, d.len});
          check_value({s.name, " tag"}, exp_desc[ch].tag, d.tag);
        end
      end
    endcase
  endtask

  task automatic build_table();
    add_step("fw_id", OP_RD, `REG_FW_ID, 0, 0, GPIN_IDLE, 0, `FW_ID_VAL);
    add_step("fw_ver", OP_RD, `REG_FW_VER, 0, 0, GPIN_IDLE, 0, `FW_VER_VAL);
    add_step("board_id", OP_RD, `REG_BOARD_ID, 0, 0, GPIN_IDLE, 0, `BOARD_ID_VAL);
    add_step("board_ver", OP_RD, `REG_BOARD_VER, 0, 0, GPIN_IDLE, 0, `BOARD_VER_VAL);
    add_step("if_count", OP_RD, `REG_IF_COUNT, 0, 0, GPIN_IDLE, 0, `IF_COUNT_VAL);
    add_step("dma_en_rst", OP_RD, `REG_DMA_ENABLE, 0, 0, GPIN_IDLE, 0, 32'h1);
    add_step("pins_rst", OP_PINS, 0, 0, 0, GPIN_IDLE, 0, 32'h8003_0A11);
    add_step("dma_en_clr", OP_WR, `REG_DMA_ENABLE, 0, 4'hF, GPIN_IDLE, 0, 0);
    add_step("dma_en_rd", OP_RD, `REG_DMA_ENABLE, 0, 0, GPIN_IDLE, 0, 32'h0);
    add_step("pins_en_off", OP_PINS, 0, 0, 0, GPIN_IDLE, 0, 32'h0003_0A11);
    // Byte lanes: 0 resetl/lpmode, 1 modsell, 2 scl/sda
    add_step("gpio_b0", OP_WR, `REG_GPIO_OUT, 32'h0000_0044, 4'h1, GPIN_IDLE, 0, 0);
    add_step("gpio_b0_rd", OP_RD, `REG_GPIO_OUT, 0, 0, GPIN_IDLE, 0, 32'h0003_0A44);
    add_step("gpio_b0_pins", OP_PINS, 0, 0, 0, GPIN_IDLE, 0, 32'h0003_0A44);
    add_step("gpio_b2", OP_WR, `REG_GPIO_OUT, 32'h0001_0011, 4'h4, GPIN_IDLE, 0, 0);
    add_step("gpio_b2_rd", OP_RD, `REG_GPIO_OUT, 0, 0, GPIN_IDLE, 0, 32'h0001_0A44);
    add_step("gpio_b1", OP_WR, `REG_GPIO_OUT, 32'h0000_0200, 4'h2, GPIN_IDLE, 0, 0);
    add_step("gpio_b1_pins", OP_PINS, 0, 0, 0, GPIN_IDLE, 0, 32'h0001_0244);
    add_step("gpio_in_set", OP_IDLE, 0, 0, 0, 32'h0002_0402, 0, 0);
    add_step("gpio_in_rd", OP_RD, `REG_GPIO_IN, 0, 0, 32'h0002_0402, 0, 32'h0002_0646);
    add_step("rd_lo", OP_WR, 16'h0440, 32'h1111_2222, 4'hF, GPIN_IDLE, 0, 0);
    add_step("rd_hi", OP_WR, 16'h0444, 32'h3333_4444, 4'hF, GPIN_IDLE, 0, 0);
    add_step("rd_ram", OP_WR, 16'h0448, 32'h5555_6666, 4'hF, GPIN_IDLE, 0, 0);
    add_step("rd_len", OP_WR, 16'h0450, 32'h0000_0100, 4'hF, GPIN_IDLE, 0, 0);
    add_step("rd_tag", OP_WR, 16'h0454, 32'h0000_00A5, 4'hF, GPIN_IDLE, 0, 0);
    add_step("rd_desc_up", OP_DESC, 16'h0440, 0, 0, GPIN_IDLE, 0, 32'h1);
    add_step("rd_wait", OP_IDLE, 0, 0, 0, GPIN_IDLE, 2'b00, 0);
    add_step("rd_desc_held", OP_DESC, 16'h0440, 0, 0, GPIN_IDLE, 0, 32'h1);
    add_step("rd_take", OP_IDLE, 0, 0, 0, GPIN_IDLE, 2'b01, 0);
    add_step("rd_desc_gone", OP_DESC, 16'h0440, 0, 0, GPIN_IDLE, 0, 32'h0);
    add_step("wr_lo", OP_WR, 16'h0460, 32'h89AB_CDEF, 4'hF, GPIN_IDLE, 0, 0);
    add_step("wr_hi", OP_WR, 16'h0464, 32'h0123_4567, 4'hF, GPIN_IDLE, 0, 0);
    add_step("wr_ram", OP_WR, 16'h0468, 32'h0000_8000, 4'hF, GPIN_IDLE, 0, 0);
    add_step("wr_len", OP_WR, 16'h0470, 32'h0000_0040, 4'hF, GPIN_IDLE, 0, 0);
    add_step("wr_tag", OP_WR, 16'h0474, 32'h0000_005A, 4'hF, GPIN_IDLE, 0, 0);
    add_step("wr_other_rdy", OP_IDLE, 0, 0, 0, GPIN_IDLE, 2'b01, 0);
    add_step("wr_desc_held", OP_DESC, 16'h0460, 0, 0, GPIN_IDLE, 0, 32'h1);
    add_step("wr_take", OP_IDLE, 0, 0, 0, GPIN_IDLE, 2'b10, 0);
    add_step("wr_desc_gone", OP_DESC, 16'h0460, 0, 0, GPIN_IDLE, 0, 32'h0);
    add_step("rd_st_1", OP_STAT, 16'h0440, 32'h1, 0, GPIN_IDLE, 0, 0);
    add_step("rd_st_4", OP_STAT, 16'h0440, 32'h4, 0, GPIN_IDLE, 0, 0);
    add_step("rd_status", OP_RD, 16'h0458, 0, 0, GPIN_IDLE, 0, 32'h5);
    add_step("rd_status_clr", OP_RD, 16'h0458, 0, 0, GPIN_IDLE, 0, 32'h0);
    add_step("wr_st_1", OP_STAT, 16'h0460, 32'h1, 0, GPIN_IDLE, 0, 0);
    add_step("wr_st_4", OP_STAT, 16'h0460, 32'h4, 0, GPIN_IDLE, 0, 0);
    add_step("wr_status", OP_RD, 16'h0478, 0, 0, GPIN_IDLE, 0, 32'h5);
    add_step("wr_status_clr", OP_RD, 16'h0478, 0, 0, GPIN_IDLE, 0, 32'h0);
  endtask

  initial begin
    awaddr = '0;
    araddr = '0;
    awvalid = 1'b0;
    wvalid = 1'b0;
    bready = 1'b0;
    arvalid = 1'b0;
    rready = 1'b0;
    wdata = '0;
    wstrb = '0;
    q1_stat = '0;
    q2_stat = '0;
    scl_in = 1'b1;
    sda_in = 1'b1;
    rd_ready = 1'b0;
    wr_ready = 1'b0;
    rd_st_valid = 1'b0;
    wr_st_valid = 1'b0;
    rd_st_tag = $random(seed);
    wr_st_tag = $random(seed);
    exp_desc[0] = '0;
    exp_desc[1] = '0;
    build_table();
    table_ready = 1'b1;
    wait (!pcie_rst);
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end
    $display("RESULT: PASS");
    $finish;
  end

  initial begin
    wait (table_ready);
    repeat (steps.size() * 40) @(posedge pcie_clk);
    $display("Timeout, the stimulus table did not finish in time");
    $display("RESULT: FAIL");
    $fatal(1, "Watchdog expired");
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+include
logic/pcie_config_pkg.sv
logic/cfg_bus_slave.sv
logic/ctrl_regs.sv
logic/gpio_regs.sv
logic/dma_desc_channel.sv
logic/pcie_config.sv
dv/tb_clock_gen.sv
dv/pcie_config_checker.sv
dv/pcie_config_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert \
  --top-module pcie_config_tb \
  -f sources.f \
  --Mdir obj_dir -o pcie_config_sim

# The simulator exits non-zero on $fatal, the log decides
./obj_dir/pcie_config_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "RESULT: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
  echo "Simulation ended without a result line"
  exit 1
fi
